//--- hdl/uart_pkg.sv
// Shared timing and buffer constants for the serial echo subsystem
// Used by the receiver, transmitter, FIFO and the testbench

package uart_pkg;

  //////////////////////////////////////////////////
  // Serial timing
  //////////////////////////////////////////////////

  // Clock cycles per serial bit
  // Kept small for short simulations, set to clock / baud for a real build
  localparam int unsigned CLKS_PER_BIT = 32'd16;

  // Offset from the start edge to the middle of the start bit
  localparam int unsigned HALF_BIT = (CLKS_PER_BIT - 1) / 2;

  // Width of the bit-period counters
  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  //////////////////////////////////////////////////
  // Byte buffer
  //////////////////////////////////////////////////

  // Number of bytes held between receiver and transmitter
  localparam int FIFO_DEPTH = 16;

  // Pointer width, depth is a power of two so pointers wrap on their own
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

endpackage

//--- hdl/uart_rx.sv
// 8N1 UART receiver with input synchronizer
// Start bit is confirmed at mid-bit, stop bit level is checked

`timescale 1ns/1ps

module uart_rx
(
  input  logic       i_Clock,
  input  logic       i_reset,
  input  logic       i_rx_serial,
  output logic       o_rx_dv,
  output logic [7:0] o_rx_byte,
  output logic       o_frame_error
);

  import uart_pkg::*;

  // FSM state codes
  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_START   = 3'd1;
  localparam logic [2:0] S_DATA    = 3'd2;
  localparam logic [2:0] S_STOP    = 3'd3;
  localparam logic [2:0] S_CLEANUP = 3'd4;

  // Two-flop synchronizer for the asynchronous line
  logic rx_meta;
  logic rx_sync;

  logic [2:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;

  // Bit-center timing
  logic half_reached;
  logic bit_end;
  logic data_sample;

  // Received byte, assembled LSB first
  logic [7:0] rx_shift;

  //////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////

  // Idle line level is high, so reset loads ones
  always_ff @(posedge i_Clock)
  begin
    if (i_reset)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= i_rx_serial;
      rx_sync <= rx_meta;
    end
  end

  assign half_reached = (clk_cnt == CNT_W'(HALF_BIT));
  assign bit_end      = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // One sample per data bit, at the bit center
  assign data_sample  = (state == S_DATA) && bit_end;

  //////////////////////////////////////////////////
  // Receive FSM
  //////////////////////////////////////////////////

  always_ff @(posedge i_Clock)
  begin
    if (i_reset)
    begin
      state         <= S_IDLE;
      clk_cnt       <= '0;
      bit_idx       <= '0;
      o_rx_dv       <= 1'b0;
      o_frame_error <= 1'b0;
    end
    else
    begin
      // Strobes last a single cycle
      o_rx_dv       <= 1'b0;
      o_frame_error <= 1'b0;

      case (state)
        S_IDLE:
        begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // Falling edge, possible start bit
          if (!rx_sync)
            state <= S_START;
        end

        S_START:
        begin
          // Recheck at mid-bit, a short low pulse is a glitch
          if (half_reached)
          begin
            clk_cnt <= '0;
            if (!rx_sync)
              state <= S_DATA;
            else
              state <= S_IDLE;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end

        S_DATA:
        begin
          // Counter now lines up with bit centers
          if (bit_end)
          begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7)
            begin
              bit_idx <= '0;
              state   <= S_STOP;
            end
            else
              bit_idx <= bit_idx + 1'b1;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end

        S_STOP:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            // Stop high gives a byte, stop low a framing error
            if (rx_sync)
              o_rx_dv <= 1'b1;
            else
              o_frame_error <= 1'b1;
            state <= S_CLEANUP;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end

        S_CLEANUP:
        begin
          // Hold here until the line is back high
          if (rx_sync)
            state <= S_IDLE;
        end

        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Shift in at each data bit center, LSB arrives first
  always_ff @(posedge i_Clock)
  begin
    if (data_sample)
      rx_shift <= {rx_sync, rx_shift[7:1]};
  end

  assign o_rx_byte = rx_shift;

endmodule

//--- hdl/byte_fifo.sv
// Synchronous byte FIFO with full and empty tracking
// Head entry is shown before the pop and writes to a full buffer are dropped

`timescale 1ns/1ps

module byte_fifo
(
  input  logic       i_Clock,
  input  logic       i_reset,
  input  logic       i_wr,
  input  logic [7:0] i_wr_data,
  input  logic       i_rd,
  output logic [7:0] o_rd_data,
  output logic       o_empty,
  output logic       o_overflow
);

  import uart_pkg::*;

  // Byte storage
  logic [7:0] mem [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;

  // One extra bit so a full buffer is distinct from empty
  logic [FIFO_AW:0] count;

  logic full;
  logic do_wr;
  logic do_rd;

  //////////////////////////////////////////////////
  // Flags and qualified requests
  //////////////////////////////////////////////////

  assign full    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign o_empty = (count == '0);

  // Pop ignored on empty
  assign do_rd = i_rd && !o_empty;

  // A pop in the same cycle frees the slot for the write
  assign do_wr = i_wr && (!full || do_rd);

  // Dropped byte is flagged in the write cycle
  assign o_overflow = i_wr && !do_wr;

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge i_Clock)
  begin
    if (i_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Pointers wrap at FIFO_DEPTH
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;

      // Simultaneous write and read leaves count unchanged
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

  // Memory write port
  always_ff @(posedge i_Clock)
  begin
    if (do_wr)
      mem[wr_ptr] <= i_wr_data;
  end

  // Head entry is read combinationally
  assign o_rd_data = mem[rd_ptr];

endmodule

//--- hdl/uart_tx.sv
// 8N1 UART transmitter fed from the byte FIFO
// Pops one byte when idle and not paused, then sends start, data, stop

`timescale 1ns/1ps

module uart_tx
(
  input  logic       i_Clock,
  input  logic       i_reset,
  input  logic       i_pause,
  input  logic       i_empty,
  input  logic [7:0] i_data,
  output logic       o_pop,
  output logic       o_tx_serial,
  output logic       o_tx_busy
);

  import uart_pkg::*;

  // FSM state codes
  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic [1:0]       state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic             bit_end;

  // Byte being sent, bit 0 is the next one on the line
  logic [7:0] tx_shift;

  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // Pause only blocks new frames, a started frame runs to the end
  assign o_pop = (state == S_IDLE) && !i_empty && !i_pause;

  //////////////////////////////////////////////////
  // Transmit FSM
  //////////////////////////////////////////////////

  always_ff @(posedge i_Clock)
  begin
    if (i_reset)
    begin
      state       <= S_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      o_tx_serial <= 1'b1;
      o_tx_busy   <= 1'b0;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          clk_cnt     <= '0;
          bit_idx     <= '0;
          o_tx_serial <= 1'b1;
          // Start bit begins the cycle after the pop
          if (o_pop)
          begin
            o_tx_serial <= 1'b0;
            o_tx_busy   <= 1'b1;
            state       <= S_START;
          end
        end

        S_START:
        begin
          if (bit_end)
          begin
            clk_cnt     <= '0;
            // First data bit, LSB
            o_tx_serial <= tx_shift[0];
            state       <= S_DATA;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end

        S_DATA:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7)
            begin
              // Stop bit
              bit_idx     <= '0;
              o_tx_serial <= 1'b1;
              state       <= S_STOP;
            end
            else
            begin
              bit_idx     <= bit_idx + 1'b1;
              // Next bit, shift happens on the same edge
              o_tx_serial <= tx_shift[1];
            end
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end

        S_STOP:
        begin
          // Busy drops here, a new pop may follow at once
          if (bit_end)
          begin
            clk_cnt   <= '0;
            o_tx_busy <= 1'b0;
            state     <= S_IDLE;
          end
          else
            clk_cnt <= clk_cnt + 1'b1;
        end

        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Load on pop, shift right at each data bit end
  always_ff @(posedge i_Clock)
  begin
    if (o_pop)
      tx_shift <= i_data;
    else if ((state == S_DATA) && bit_end)
      tx_shift <= {1'b1, tx_shift[7:1]};
  end

endmodule

//--- hdl/uart_echo.sv
// Serial echo top level
// Receiver feeds the byte FIFO, transmitter drains it

`timescale 1ns/1ps

module uart_echo
(
  input  logic i_Clock,
  input  logic i_reset,
  input  logic i_rx_serial,
  input  logic i_tx_pause,
  output logic o_tx_serial,
  output logic o_tx_busy,
  output logic o_overflow,
  output logic o_frame_error
);

  // Receiver to FIFO
  logic [7:0] rx_byte;
  logic       rx_dv;

  // FIFO to transmitter
  logic [7:0] fifo_data;
  logic       fifo_empty;
  logic       fifo_pop;

  // Producer, never stalled
  uart_rx uart_rx_inst
  (
    .i_Clock       (i_Clock),
    .i_reset       (i_reset),
    .i_rx_serial   (i_rx_serial),
    .o_rx_dv       (rx_dv),
    .o_rx_byte     (rx_byte),
    .o_frame_error (o_frame_error)
  );

  // Buffer, overflow when a byte arrives while full
  byte_fifo byte_fifo_inst
  (
    .i_Clock    (i_Clock),
    .i_reset    (i_reset),
    .i_wr       (rx_dv),
    .i_wr_data  (rx_byte),
    .i_rd       (fifo_pop),
    .o_rd_data  (fifo_data),
    .o_empty    (fifo_empty),
    .o_overflow (o_overflow)
  );

  // Consumer, held off by pause between frames
  uart_tx uart_tx_inst
  (
    .i_Clock     (i_Clock),
    .i_reset     (i_reset),
    .i_pause     (i_tx_pause),
    .i_empty     (fifo_empty),
    .i_data      (fifo_data),
    .o_pop       (fifo_pop),
    .o_tx_serial (o_tx_serial),
    .o_tx_busy   (o_tx_busy)
  );

endmodule

//--- testbench/uart_echo_checker.sv
// Serial output decoder and scoreboard for the echo testbench
// Holds the expected-byte queue, counts frames and status pulses

`timescale 1ns/1ps

module uart_echo_checker
(
  input  logic       i_Clock,
  input  logic       i_reset,
  input  logic       i_tx_serial,
  input  logic       i_tx_busy,
  input  logic       i_overflow,
  input  logic       i_frame_error,
  input  logic       i_push,
  input  logic [7:0] i_push_data,
  output int         o_pending,
  output int         o_start_count,
  output int         o_frame_count,
  output int         o_overflow_count,
  output int         o_frame_error_count,
  output int         o_error_count
);

  import uart_pkg::*;

  // Bytes the DUT still owes on its serial output in arrival order
  logic [7:0] expected_q[$];

  // Frame decoder state
  logic       in_frame;
  int         cnt;
  int         bit_num;
  logic [7:0] shift;
  logic [7:0] head;

  //////////////////////////////////////////////////
  // Decode and compare once per clock
  //////////////////////////////////////////////////

  always @(posedge i_Clock)
  begin
    if (i_reset)
    begin
      expected_q.delete();
      in_frame            = 1'b0;
      cnt                 = 0;
      bit_num             = 0;
      shift               = '0;
      o_pending           = 0;
      o_start_count       = 0;
      o_frame_count       = 0;
      o_overflow_count    = 0;
      o_frame_error_count = 0;
      o_error_count       = 0;
    end
    else
    begin
      if (i_push)
        expected_q.push_back(i_push_data);
      // Status pulses last one cycle each
      if (i_overflow)
        o_overflow_count++;
      if (i_frame_error)
        o_frame_error_count++;

      if (!in_frame)
      begin
        // Low on an idle line means the start bit began one cycle ago
        if (!i_tx_serial)
        begin
          in_frame = 1'b1;
          cnt      = 1;
          bit_num  = 0;
          o_start_count++;
        end
      end
      else
      begin
        cnt++;
        // Bit k sampled near its center
        if (cnt == int'(HALF_BIT) + bit_num * int'(CLKS_PER_BIT))
        begin
          // Busy covers the whole frame up to the end of the stop bit
          if (!i_tx_busy)
          begin
            $display("MISMATCH at %0t: o_tx_busy low inside a frame at bit %0d",
                     $time, bit_num);
            o_error_count++;
          end
          if (bit_num == 0)
          begin
            if (i_tx_serial)
            begin
              $display("MISMATCH at %0t: start bit high at its center", $time);
              o_error_count++;
            end
          end
          else if (bit_num <= 8)
            // LSB first
            shift = {i_tx_serial, shift[7:1]};
          else
          begin
            if (!i_tx_serial)
            begin
              $display("MISMATCH at %0t: stop bit low for byte 0x%02h", $time, shift);
              o_error_count++;
            end
            if (expected_q.size() == 0)
            begin
              $display("Unexpected frame at %0t: byte 0x%02h sent with nothing pending",
                       $time, shift);
              o_error_count++;
            end
            else
            begin
              head = expected_q.pop_front();
              if (shift !== head)
              begin
                $display("MISMATCH at %0t: echoed byte 0x%02h, expected 0x%02h",
                         $time, shift, head);
                o_error_count++;
              end
            end
            o_frame_count++;
            in_frame = 1'b0;
          end
          bit_num++;
        end
      end
      o_pending = expected_q.size();
    end
  end

endmodule

//--- testbench/uart_echo_tb.sv
// Testbench for the serial echo top level
// Clock and reset, seeded random 8N1 stimulus, expected-byte model, test sequence

`timescale 1ns/1ps

module uart_echo_tb;

  import uart_pkg::*;

  // DUT ports
  logic i_Clock;
  logic i_reset;
  logic i_rx_serial;
  logic i_tx_pause;
  logic o_tx_serial;
  logic o_tx_busy;
  logic o_overflow;
  logic o_frame_error;

  // Model side of the checker
  logic       push;
  logic [7:0] push_data;
  int         pending;
  int         start_count;
  int         frame_count;
  int         overflow_count;
  int         frame_error_count;
  int         check_errors;

  // Bookkeeping
  int tb_errors;
  int expected_overflows;
  int tests_run;
  int tests_failed;
  int errors_at_start;

  // Counter snapshots at the start of a test
  int starts_0;
  int frames_0;
  int overflows_0;
  int frame_errors_0;

  uart_echo uart_echo_inst
  (
    .i_Clock       (i_Clock),
    .i_reset       (i_reset),
    .i_rx_serial   (i_rx_serial),
    .i_tx_pause    (i_tx_pause),
    .o_tx_serial   (o_tx_serial),
    .o_tx_busy     (o_tx_busy),
    .o_overflow    (o_overflow),
    .o_frame_error (o_frame_error)
  );

  uart_echo_checker checker_inst
  (
    .i_Clock             (i_Clock),
    .i_reset             (i_reset),
    .i_tx_serial         (o_tx_serial),
    .i_tx_busy           (o_tx_busy),
    .i_overflow          (o_overflow),
    .i_frame_error       (o_frame_error),
    .i_push              (push),
    .i_push_data         (push_data),
    .o_pending           (pending),
    .o_start_count       (start_count),
    .o_frame_count       (frame_count),
    .o_overflow_count    (overflow_count),
    .o_frame_error_count (frame_error_count),
    .o_error_count       (check_errors)
  );

  // 8 ns clock
  initial
  begin
    i_Clock = 1'b0;
    forever
      #4 i_Clock = ~i_Clock;
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge i_Clock);
    #1;
  endtask

  task automatic idle_gap(input int bits);
    repeat (bits * CLKS_PER_BIT)
      step();
  endtask

  // One 8N1 frame with a selectable stop level for bad frames
  task automatic send_frame(input logic [7:0] data, input logic stop_level);
    int i;
    i_rx_serial = 1'b0;
    idle_gap(1);
    for (i = 0; i < 8; i++)
    begin
      i_rx_serial = data[i];
      idle_gap(1);
    end
    i_rx_serial = stop_level;
    idle_gap(1);
    i_rx_serial = 1'b1;
  endtask

  // Model keeps the byte if the DUT has room and otherwise expects an overflow
  task automatic record_byte(input logic [7:0] data);
    if (pending < FIFO_DEPTH)
    begin
      push_data = data;
      push      = 1'b1;
      step();
      push      = 1'b0;
    end
    else
      expected_overflows++;
  endtask

  task automatic send_good(input logic [7:0] data, input int gap_bits);
    send_frame(data, 1'b1);
    record_byte(data);
    idle_gap(gap_bits);
  endtask

  // Short low pulse that the start-bit recheck rejects
  task automatic send_glitch(input int low_cycles);
    i_rx_serial = 1'b0;
    repeat (low_cycles)
      step();
    i_rx_serial = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Checks and waits
  //////////////////////////////////////////////////

  task automatic check_level(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
      tb_errors++;
    end
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected)
    begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      tb_errors++;
    end
  endtask

  task automatic expect_idle_outputs();
    check_level("o_tx_serial", o_tx_serial, 1'b1);
    check_level("o_tx_busy", o_tx_busy, 1'b0);
    check_level("o_overflow", o_overflow, 1'b0);
    check_level("o_frame_error", o_frame_error, 1'b0);
  endtask

  // Until every modelled byte is echoed and the transmitter is idle
  task automatic wait_drained();
    int cycles;
    int limit;
    cycles = 0;
    limit  = (FIFO_DEPTH + 4) * 12 * int'(CLKS_PER_BIT);
    while ((pending != 0 || o_tx_busy) && cycles < limit)
    begin
      step();
      cycles++;
    end
    if (pending != 0 || o_tx_busy)
    begin
      $display("Timeout at %0t: %0d bytes never came back after %0d cycles",
               $time, pending, cycles);
      tb_errors++;
    end
  endtask

  // Output high and not busy for 12 bit periods in a row
  task automatic wait_idle();
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < 12 * int'(CLKS_PER_BIT) && cycles < 40 * int'(CLKS_PER_BIT))
    begin
      step();
      cycles++;
      if (o_tx_serial && !o_tx_busy)
        quiet++;
      else
        quiet = 0;
    end
    if (quiet < 12 * int'(CLKS_PER_BIT))
    begin
      $display("Timeout at %0t: serial output never settled to idle", $time);
      tb_errors++;
    end
  endtask

  task automatic begin_test();
    errors_at_start = tb_errors + check_errors;
    starts_0        = start_count;
    frames_0        = frame_count;
    overflows_0     = overflow_count;
    frame_errors_0  = frame_error_count;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = tb_errors + check_errors - errors_at_start;
    tests_run++;
    if (errs != 0)
    begin
      tests_failed++;
      $display("Test %s: FAILED with %0d errors", name, errs);
    end
    else
      $display("Test %s: ok", name);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    int i;
    logic [7:0] data;
    void'($urandom(32'h7e6d_4e35));
    i_reset            = 1'b1;
    i_rx_serial        = 1'b1;
    i_tx_pause         = 1'b0;
    push               = 1'b0;
    push_data          = '0;
    tb_errors          = 0;
    expected_overflows = 0;
    tests_run          = 0;
    tests_failed       = 0;

    // Outputs idle during reset and just after it
    begin_test();
    repeat (4)
    begin
      step();
      expect_idle_outputs();
    end
    i_reset = 1'b0;
    repeat (3)
    begin
      step();
      expect_idle_outputs();
    end
    end_test("reset state");

    // Random bytes with random gaps come back in order
    begin_test();
    for (i = 0; i < 40; i++)
    begin
      data = 8'($urandom);
      send_good(data, $urandom_range(3, 0));
    end
    wait_drained();
    check_count("echoed frames", frame_count - frames_0, 40);
    check_count("overflow pulses", overflow_count - overflows_0, 0);
    check_count("frame error pulses", frame_error_count - frame_errors_0, 0);
    end_test("echo order");

    // Stop bit low and the line high again before the next start
    begin_test();
    for (i = 0; i < 4; i++)
    begin
      data = 8'($urandom);
      send_frame(data, 1'b0);
      idle_gap(1 + $urandom_range(2, 0));
    end
    idle_gap(2);
    check_count("frame error pulses", frame_error_count - frame_errors_0, 4);
    check_count("output frames", start_count - starts_0, 0);
    for (i = 0; i < 6; i++)
    begin
      data = 8'($urandom);
      send_good(data, $urandom_range(3, 0));
    end
    wait_drained();
    check_count("echoed frames", frame_count - frames_0, 6);
    check_count("frame error pulses", frame_error_count - frame_errors_0, 4);
    end_test("framing error");

    // Pulses shorter than half a bit
    begin_test();
    for (i = 0; i < 5; i++)
    begin
      send_glitch($urandom_range(HALF_BIT - 1, 1));
      idle_gap(2);
    end
    check_count("output frames", start_count - starts_0, 0);
    check_count("frame error pulses", frame_error_count - frame_errors_0, 0);
    check_count("overflow pulses", overflow_count - overflows_0, 0);
    end_test("start glitch");

    // Fill the FIFO past its depth while the transmitter is held
    begin_test();
    expected_overflows = 0;
    i_tx_pause         = 1'b1;
    for (i = 0; i < FIFO_DEPTH + 3; i++)
    begin
      data = 8'($urandom);
      send_good(data, $urandom_range(3, 0));
    end
    idle_gap(2);
    check_count("output frames while paused", start_count - starts_0, 0);
    check_count("overflow pulses", overflow_count - overflows_0, expected_overflows);
    check_count("expected overflows", expected_overflows, 3);
    i_tx_pause = 1'b0;
    wait_drained();
    check_count("echoed frames", frame_count - frames_0, FIFO_DEPTH);
    end_test("pause and fill");

    // Nothing left in flight
    begin_test();
    wait_idle();
    check_count("model bytes left", pending, 0);
    check_level("o_tx_busy", o_tx_busy, 1'b0);
    end_test("final idle");

    $display("Summary: %0d tests, %0d failed, %0d frames echoed, %0d errors",
             tests_run, tests_failed, frame_count, tb_errors + check_errors);
    if (tb_errors + check_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- list.f
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_echo.sv
testbench/uart_echo_checker.sv
testbench/uart_echo_tb.sv

//--- Makefile
# Verilator build and run of the serial echo testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f list.f --top-module uart_echo_tb -o uart_echo_sim
	./obj_dir/uart_echo_sim | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
